// ==== include/rv32_opcodes.svh ====
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

`define RV32_LUI    32'b?????????????????????????0110111
`define RV32_AUIPC  32'b?????????????????????????0010111
`define RV32_JAL    32'b?????????????????????????1101111
`define RV32_JALR   32'b?????????????????000?????1100111
`define RV32_BEQ    32'b?????????????????000?????1100011
`define RV32_BNE    32'b?????????????????001?????1100011
`define RV32_BLT    32'b?????????????????100?????1100011
`define RV32_BGE    32'b?????????????????101?????1100011
`define RV32_BLTU   32'b?????????????????110?????1100011
`define RV32_BGEU   32'b?????????????????111?????1100011
`define RV32_ADDI   32'b?????????????????000?????0010011
`define RV32_SLTI   32'b?????????????????010?????0010011
`define RV32_SLTIU  32'b?????????????????011?????0010011
`define RV32_XORI   32'b?????????????????100?????0010011
`define RV32_ORI    32'b?????????????????110?????0010011
`define RV32_ANDI   32'b?????????????????111?????0010011
`define RV32_SLLI   32'b0000000??????????001?????0010011
`define RV32_SRLI   32'b0000000??????????101?????0010011
`define RV32_SRAI   32'b0100000??????????101?????0010011
`define RV32_ADD    32'b0000000??????????000?????0110011
`define RV32_SUB    32'b0100000??????????000?????0110011
`define RV32_SLL    32'b0000000??????????001?????0110011
`define RV32_SLT    32'b0000000??????????010?????0110011
`define RV32_SLTU   32'b0000000??????????011?????0110011
`define RV32_XOR    32'b0000000??????????100?????0110011
`define RV32_SRL    32'b0000000??????????101?????0110011
`define RV32_SRA    32'b0100000??????????101?????0110011
`define RV32_OR     32'b0000000??????????110?????0110011
`define RV32_AND    32'b0000000??????????111?????0110011
`define RV32_MUL    32'b0000001??????????000?????0110011
`define RV32_MULH   32'b0000001??????????001?????0110011
`define RV32_MULHSU 32'b0000001??????????010?????0110011
`define RV32_MULHU  32'b0000001??????????011?????0110011
`define RV32_WFI    32'b00010000010100000000000001110011

`endif

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_rv_exec -o tb_rv_exec_sim &&
./obj_dir/tb_rv_exec_sim || { echo "simulation run failed"; exit 1; }

// ==== source/execute_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
	input  wire logic  clock,
	input  wire logic  rst_n,
	decode_if.consumer dec,
	regread_if.requester rf,
	retire_if.producer ret
);

	localparam int XLEN = rv_isa_pkg::XLEN;

	rv_pipe_pkg::decoded_inst_t d;
	rv_pipe_pkg::exec_result_t nxt;
	rv_isa_pkg::alu_op_e alu_op;
	rv_isa_pkg::mult_op_e mult_op;
	rv_isa_pkg::br_op_e br_op;
	logic fwd1;
	logic fwd2;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] mul_out;
	logic [XLEN-1:0] sum;
	logic [63:0] mul_a;
	logic [63:0] mul_b;
	logic [63:0] prod;
	logic br_cond;

	assign d = dec.inst;
	assign alu_op = rv_isa_pkg::alu_op_e'(d.op);
	assign mult_op = rv_isa_pkg::mult_op_e'(d.op[1:0]);
	assign br_op = rv_isa_pkg::br_op_e'(d.op[2:0]);

	assign rf.rs1_idx = d.rs1;
	assign rf.rs2_idx = d.rs2;

	// bypass from our own registered result, rf not written yet
	assign fwd1 = ret.valid && (ret.res.rd != '0) && (ret.res.rd == d.rs1);
	assign fwd2 = ret.valid && (ret.res.rd != '0) && (ret.res.rd == d.rs2);
	assign rs1_val = fwd1 ? ret.res.value : rf.rs1_data;
	assign rs2_val = fwd2 ? ret.res.value : rf.rs2_data;

	always_comb begin
		case (d.opa_sel)
			rv_isa_pkg::OPA_IS_PC:   opa = d.pc;
			rv_isa_pkg::OPA_IS_ZERO: opa = '0;
			default:                 opa = rs1_val;
		endcase
		opb = (d.opb_sel == rv_isa_pkg::OPB_IS_RS2) ? rs2_val : d.imm;
	end

	always_comb begin
		case (alu_op)
			rv_isa_pkg::ALU_SUB:  alu_out = opa - opb;
			rv_isa_pkg::ALU_SLT:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
			rv_isa_pkg::ALU_SLTU: alu_out = {31'b0, opa < opb};
			rv_isa_pkg::ALU_AND:  alu_out = opa & opb;
			rv_isa_pkg::ALU_OR:   alu_out = opa | opb;
			rv_isa_pkg::ALU_XOR:  alu_out = opa ^ opb;
			rv_isa_pkg::ALU_SLL:  alu_out = opa << opb[4:0];
			rv_isa_pkg::ALU_SRL:  alu_out = opa >> opb[4:0];
			rv_isa_pkg::ALU_SRA:  alu_out = $unsigned($signed(opa) >>> opb[4:0]);
			default:              alu_out = opa + opb;
		endcase
	end

	// one 64x64 multiply, operands extended per variant
	always_comb begin
		mul_a = {32'b0, opa};
		mul_b = {32'b0, opb};
		if (mult_op == rv_isa_pkg::MULH || mult_op == rv_isa_pkg::MULHSU)
			mul_a = {{32{opa[31]}}, opa};
		if (mult_op == rv_isa_pkg::MULH)
			mul_b = {{32{opb[31]}}, opb};
		prod = mul_a * mul_b; // low 64 bits exact in two's complement
		mul_out = (mult_op == rv_isa_pkg::MULT) ? prod[31:0] : prod[63:32];
	end

	always_comb begin
		case (br_op)
			rv_isa_pkg::BR_EQ:  br_cond = rs1_val == rs2_val;
			rv_isa_pkg::BR_NE:  br_cond = rs1_val != rs2_val;
			rv_isa_pkg::BR_LT:  br_cond = $signed(rs1_val) < $signed(rs2_val);
			rv_isa_pkg::BR_GE:  br_cond = $signed(rs1_val) >= $signed(rs2_val);
			rv_isa_pkg::BR_LTU: br_cond = rs1_val < rs2_val;
			rv_isa_pkg::BR_GEU: br_cond = rs1_val >= rs2_val;
			default:            br_cond = 1'b1; // jal, jalr
		endcase
	end

	assign sum = opa + opb;

	always_comb begin
		nxt.rd = d.rd;
		case (d.fu_sel)
			rv_isa_pkg::FU_MULT:   nxt.value = mul_out;
			rv_isa_pkg::FU_BRANCH: nxt.value = d.pc + 32'd4; // link
			default:               nxt.value = alu_out;
		endcase
		nxt.branch_taken = (d.fu_sel == rv_isa_pkg::FU_BRANCH) && br_cond;
		nxt.branch_target = {sum[XLEN-1:1], 1'b0}; // jalr clears bit 0, others already even
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			ret.valid <= 1'b0;
		else
			ret.valid <= dec.valid;
	end

	always_ff @(posedge clock) begin
		ret.res <= nxt;
	end

	a_taken_only_branch: assert property (@(posedge clock) disable iff (!rst_n)
		dec.valid && (dec.inst.fu_sel != rv_isa_pkg::FU_BRANCH) |=> !ret.res.branch_taken);

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv32_opcodes.svh"

module inst_decoder #(
	parameter int REG_COUNT = 32
) (
	input  wire logic        clock,
	input  wire logic        rst_n,
	input  wire logic        inst_valid,
	input  wire logic [31:0] inst,
	input  wire logic [31:0] pc,
	output logic             halt,
	output logic             illegal,
	decode_if.producer       dec
);

	logic [3:0] op;
	logic known;
	logic is_wfi;
	logic bad_reg;
	logic accept;
	rv_pipe_pkg::decoded_inst_t nxt;

	// operation select; anything not listed is illegal
	always_comb begin
		op = 4'(rv_isa_pkg::ALU_ADD);
		known = 1'b1;
		is_wfi = 1'b0;
		casez (inst)
			`RV32_LUI, `RV32_AUIPC, `RV32_ADDI, `RV32_ADD: op = 4'(rv_isa_pkg::ALU_ADD);
			`RV32_SUB:                op = 4'(rv_isa_pkg::ALU_SUB);
			`RV32_SLTI, `RV32_SLT:    op = 4'(rv_isa_pkg::ALU_SLT);
			`RV32_SLTIU, `RV32_SLTU:  op = 4'(rv_isa_pkg::ALU_SLTU);
			`RV32_ANDI, `RV32_AND:    op = 4'(rv_isa_pkg::ALU_AND);
			`RV32_ORI, `RV32_OR:      op = 4'(rv_isa_pkg::ALU_OR);
			`RV32_XORI, `RV32_XOR:    op = 4'(rv_isa_pkg::ALU_XOR);
			`RV32_SLLI, `RV32_SLL:    op = 4'(rv_isa_pkg::ALU_SLL);
			`RV32_SRLI, `RV32_SRL:    op = 4'(rv_isa_pkg::ALU_SRL);
			`RV32_SRAI, `RV32_SRA:    op = 4'(rv_isa_pkg::ALU_SRA);
			`RV32_MUL:                op = 4'(rv_isa_pkg::MULT);
			`RV32_MULH:               op = 4'(rv_isa_pkg::MULH);
			`RV32_MULHSU:             op = 4'(rv_isa_pkg::MULHSU);
			`RV32_MULHU:              op = 4'(rv_isa_pkg::MULHU);
			`RV32_BEQ:                op = 4'(rv_isa_pkg::BR_EQ);
			`RV32_BNE:                op = 4'(rv_isa_pkg::BR_NE);
			`RV32_BLT:                op = 4'(rv_isa_pkg::BR_LT);
			`RV32_BGE:                op = 4'(rv_isa_pkg::BR_GE);
			`RV32_BLTU:               op = 4'(rv_isa_pkg::BR_LTU);
			`RV32_BGEU:               op = 4'(rv_isa_pkg::BR_GEU);
			`RV32_JAL, `RV32_JALR:    op = 4'(rv_isa_pkg::BR_JUMP);
			`RV32_WFI:                is_wfi = 1'b1;
			default:                  known = 1'b0; // loads, stores, csr, unknown
		endcase
	end

	// format: unit, operand selects and register fields from the major opcode
	always_comb begin
		nxt.pc = pc;
		nxt.fu_sel = rv_isa_pkg::FU_ALU;
		nxt.op = op;
		nxt.opa_sel = rv_isa_pkg::OPA_IS_RS1;
		nxt.opb_sel = rv_isa_pkg::OPB_IS_RS2;
		nxt.rd = '0;
		nxt.rs1 = '0;
		nxt.rs2 = '0;
		case (inst[6:0])
			7'b0110111, 7'b0010111: begin // lui, auipc
				nxt.opa_sel = inst[5] ? rv_isa_pkg::OPA_IS_ZERO : rv_isa_pkg::OPA_IS_PC;
				nxt.opb_sel = rv_isa_pkg::OPB_IS_U_IMM;
				nxt.rd = inst[11:7];
			end
			7'b1101111: begin // jal
				nxt.fu_sel = rv_isa_pkg::FU_BRANCH;
				nxt.opa_sel = rv_isa_pkg::OPA_IS_PC;
				nxt.opb_sel = rv_isa_pkg::OPB_IS_J_IMM;
				nxt.rd = inst[11:7];
			end
			7'b1100111: begin // jalr
				nxt.fu_sel = rv_isa_pkg::FU_BRANCH;
				nxt.opb_sel = rv_isa_pkg::OPB_IS_I_IMM;
				nxt.rd = inst[11:7];
				nxt.rs1 = inst[19:15];
			end
			7'b1100011: begin // conditional branches write nothing
				nxt.fu_sel = rv_isa_pkg::FU_BRANCH;
				nxt.opa_sel = rv_isa_pkg::OPA_IS_PC;
				nxt.opb_sel = rv_isa_pkg::OPB_IS_B_IMM;
				nxt.rs1 = inst[19:15];
				nxt.rs2 = inst[24:20];
			end
			7'b0010011: begin
				nxt.opb_sel = rv_isa_pkg::OPB_IS_I_IMM;
				nxt.rd = inst[11:7];
				nxt.rs1 = inst[19:15];
			end
			7'b0110011: begin
				nxt.fu_sel = inst[25] ? rv_isa_pkg::FU_MULT : rv_isa_pkg::FU_ALU;
				nxt.rd = inst[11:7];
				nxt.rs1 = inst[19:15];
				nxt.rs2 = inst[24:20];
			end
			default: ;
		endcase
		case (nxt.opb_sel)
			rv_isa_pkg::OPB_IS_I_IMM: nxt.imm = rv_isa_pkg::i_imm(inst);
			rv_isa_pkg::OPB_IS_U_IMM: nxt.imm = rv_isa_pkg::u_imm(inst);
			rv_isa_pkg::OPB_IS_B_IMM: nxt.imm = rv_isa_pkg::b_imm(inst);
			rv_isa_pkg::OPB_IS_J_IMM: nxt.imm = rv_isa_pkg::j_imm(inst);
			default:                  nxt.imm = '0;
		endcase
	end

	// rv32e has only 16 registers
	assign bad_reg = (nxt.rd >= REG_COUNT) || (nxt.rs1 >= REG_COUNT) || (nxt.rs2 >= REG_COUNT);
	assign accept = inst_valid && !halt; // dead after wfi

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
			illegal <= 1'b0;
			halt <= 1'b0;
		end else begin
			dec.valid <= accept && known && !is_wfi && !bad_reg;
			illegal <= accept && (!known || bad_reg);
			if (accept && is_wfi)
				halt <= 1'b1; // sticky
		end
	end

	always_ff @(posedge clock) begin
		dec.inst <= nxt;
	end

	a_valid_not_illegal: assert property (@(posedge clock) disable iff (!rst_n)
		!(dec.valid && illegal));

endmodule

`default_nettype wire

// ==== source/pipe_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// decoded instruction, one-cycle strobe
interface decode_if;
	logic                       valid;
	rv_pipe_pkg::decoded_inst_t inst;

	modport producer(output valid, output inst);
	modport consumer(input valid, input inst);
endinterface

// combinational register file read, x0 reads zero
interface regread_if;
	logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx;
	logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx;
	logic [rv_isa_pkg::XLEN-1:0]      rs1_data;
	logic [rv_isa_pkg::XLEN-1:0]      rs2_data;

	modport requester(
		output rs1_idx,
		output rs2_idx,
		input  rs1_data,
		input  rs2_data
	);
	modport responder(
		input  rs1_idx,
		input  rs2_idx,
		output rs1_data,
		output rs2_data
	);
endinterface

// execute result, one-cycle strobe
interface retire_if;
	logic                      valid;
	rv_pipe_pkg::exec_result_t res;

	modport producer(output valid, output res);
	modport consumer(input valid, input res);
endinterface

`default_nettype wire

// ==== source/result_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_writeback #(
	parameter int REG_COUNT = 32
) (
	input  wire logic    clock,
	input  wire logic    rst_n,
	regread_if.responder rf,
	retire_if.consumer   ret,
	output logic [31:0]  retire_count
);

	localparam int IDX_W = $clog2(REG_COUNT);

	logic [rv_isa_pkg::XLEN-1:0] regs [REG_COUNT];
	logic wr_en;

	// async reads, x0 and out of range indices read zero
	always_comb begin
		rf.rs1_data = '0;
		rf.rs2_data = '0;
		if (rf.rs1_idx != '0 && rf.rs1_idx < REG_COUNT)
			rf.rs1_data = regs[rf.rs1_idx[IDX_W-1:0]];
		if (rf.rs2_idx != '0 && rf.rs2_idx < REG_COUNT)
			rf.rs2_data = regs[rf.rs2_idx[IDX_W-1:0]];
	end

	assign wr_en = ret.valid && (ret.res.rd != '0) && (ret.res.rd < REG_COUNT);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[ret.res.rd[IDX_W-1:0]] <= ret.res.value;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			retire_count <= '0;
		else if (ret.valid)
			retire_count <= retire_count + 32'd1; // rd 0 results count too
	end

	// decoder should have filtered these
	a_rd_in_range: assert property (@(posedge clock) disable iff (!rst_n)
		ret.valid |-> (ret.res.rd < REG_COUNT));

endmodule

`default_nettype wire

// ==== source/rv_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top #(
	parameter int REG_COUNT = 32
) (
	input  wire logic        clock,
	input  wire logic        rst_n,
	input  wire logic        inst_valid,
	input  wire logic [31:0] inst,
	input  wire logic [31:0] pc,
	output logic             result_valid,
	output logic [4:0]       result_rd,
	output logic [31:0]      result_value,
	output logic             branch_taken,
	output logic [31:0]      branch_target,
	output logic             halt,
	output logic             illegal,
	output logic [31:0]      retire_count
);

	decode_if  dec_bus ();
	regread_if rf_bus ();
	retire_if  ret_bus ();

	inst_decoder #(.REG_COUNT(REG_COUNT)) inst_decoder_inst (
		.clock(clock),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc(pc),
		.halt(halt),
		.illegal(illegal),
		.dec(dec_bus.producer)
	);

	execute_unit execute_unit_inst (
		.clock(clock),
		.rst_n(rst_n),
		.dec(dec_bus.consumer),
		.rf(rf_bus.requester),
		.ret(ret_bus.producer)
	);

	result_writeback #(.REG_COUNT(REG_COUNT)) result_writeback_inst (
		.clock(clock),
		.rst_n(rst_n),
		.rf(rf_bus.responder),
		.ret(ret_bus.consumer),
		.retire_count(retire_count)
	);

	// results leave straight from the execute register
	assign result_valid = ret_bus.valid;
	assign result_rd = ret_bus.res.rd;
	assign result_value = ret_bus.res.value;
	assign branch_taken = ret_bus.res.branch_taken;
	assign branch_target = ret_bus.res.branch_target;

endmodule

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	parameter int XLEN = 32;
	parameter int REG_IDX_W = 5;

	typedef enum logic [1:0] {
		FU_ALU,
		FU_MULT,
		FU_BRANCH
	} fu_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {
		MULT,
		MULH,
		MULHSU,
		MULHU
	} mult_op_e;

	typedef enum logic [2:0] {
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU,
		BR_JUMP // jal and jalr
	} br_op_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_PC,
		OPA_IS_ZERO
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_U_IMM,
		OPB_IS_B_IMM,
		OPB_IS_J_IMM
	} opb_sel_e;

	// immediates, sign extended to XLEN
	function automatic logic [XLEN-1:0] i_imm(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[31:20]};
	endfunction

	function automatic logic [XLEN-1:0] u_imm(input logic [31:0] inst);
		return {inst[31:12], 12'b0};
	endfunction

	function automatic logic [XLEN-1:0] b_imm(input logic [31:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic logic [XLEN-1:0] j_imm(input logic [31:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

`default_nettype wire

// ==== source/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

	// decode -> execute packet, 90 bits
	typedef struct packed {
		logic [rv_isa_pkg::XLEN-1:0]      pc;
		rv_isa_pkg::fu_sel_e              fu_sel;
		logic [3:0]                       op; // alu, mult or branch op by fu_sel
		rv_isa_pkg::opa_sel_e             opa_sel;
		rv_isa_pkg::opb_sel_e             opb_sel;
		logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
		logic [rv_isa_pkg::REG_IDX_W-1:0] rs1;
		logic [rv_isa_pkg::REG_IDX_W-1:0] rs2;
		logic [rv_isa_pkg::XLEN-1:0]      imm; // already picked for the format
	} decoded_inst_t;

	// execute -> writeback packet, 70 bits
	typedef struct packed {
		logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
		logic [rv_isa_pkg::XLEN-1:0]      value;
		logic                             branch_taken;
		logic [rv_isa_pkg::XLEN-1:0]      branch_target;
	} exec_result_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/pipe_ifs.sv
source/inst_decoder.sv
source/execute_unit.sv
source/result_writeback.sv
source/rv_exec_top.sv
verification/tb_rv_exec.sv

// ==== verification/tb_rv_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec;

	localparam int REG_COUNT = 16; // rv32e build, so the register range check runs

	logic clock;
	logic rst_n;
	logic inst_valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic result_valid;
	logic [4:0] result_rd;
	logic [31:0] result_value;
	logic branch_taken;
	logic [31:0] branch_target;
	logic halt;
	logic illegal;
	logic [31:0] retire_count;

	integer seed;
	logic [31:0] cur_pc;
	logic [31:0] n_retired;
	logic [31:0] model_regs [32]; // architectural state in program order
	logic [31:0] q_inst [$];
	logic [31:0] q_pc [$];
	rv_pipe_pkg::exec_result_t q_exp [$];
	logic q_is_br [$];
	int q_due [$];

	rv_exec_top #(.REG_COUNT(REG_COUNT)) rv_exec_top_inst (
		.clock(clock),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc(pc),
		.result_valid(result_valid),
		.result_rd(result_rd),
		.result_value(result_value),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt(halt),
		.illegal(illegal),
		.retire_count(retire_count)
	);

	always #2 clock = ~clock;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input rv_pipe_pkg::exec_result_t got,
		input rv_pipe_pkg::exec_result_t exp, input logic with_target);
		if (got.rd !== exp.rd || got.value !== exp.value || got.branch_taken !== exp.branch_taken
			|| (with_target && got.branch_target !== exp.branch_target))
			abort_run($sformatf("mismatch at %0t: got rd %0d value %h taken %b target %h, %s %0d %h %b %h",
				$time, got.rd, got.value, got.branch_taken, got.branch_target,
				"expected", exp.rd, exp.value, exp.branch_taken, exp.branch_target));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic rv_pipe_pkg::exec_result_t make_res(input logic [4:0] rd,
		input logic [31:0] value, input logic taken, input logic [31:0] target);
		rv_pipe_pkg::exec_result_t r;
		r.rd = rd;
		r.value = value;
		r.branch_taken = taken;
		r.branch_target = target;
		return r;
	endfunction

	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// reference behavior straight from the isa rules
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] mul_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		longint sa;
		longint sb;
		logic [63:0] p;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		case (f3[1:0])
			2'd1: p = sa * sb;
			2'd2: p = sa * longint'({32'b0, b}); // signed x unsigned
			default: p = {32'b0, a} * {32'b0, b};
		endcase
		return (f3[1:0] == 2'd0) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic push_inst(input logic [31:0] word, input rv_pipe_pkg::exec_result_t exp,
		input logic is_br);
		q_inst.push_back(word);
		q_pc.push_back(cur_pc);
		q_exp.push_back(exp);
		q_is_br.push_back(is_br);
		if (exp.rd != 5'd0)
			model_regs[exp.rd] = exp.value; // x0 stays zero
		cur_pc = cur_pc + 32'd4;
		n_retired = n_retired + 32'd1;
	endtask

	task automatic do_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		logic [31:0] v;
		if (f7 == 7'b0000001)
			v = mul_ref(f3, model_regs[rs1], model_regs[rs2]);
		else
			v = alu_ref(f3, f7[5], model_regs[rs1], model_regs[rs2]);
		push_inst(enc_r(f7, rs2, rs1, f3, rd), make_res(rd, v, 1'b0, '0), 1'b0);
	endtask

	task automatic do_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		logic [31:0] v;
		v = alu_ref(f3, (f3 == 3'd5) && imm[10], model_regs[rs1], {{20{imm[11]}}, imm});
		push_inst(enc_i(imm, rs1, f3, rd, 7'b0010011), make_res(rd, v, 1'b0, '0), 1'b0);
	endtask

	task automatic do_u(input logic is_auipc, input logic [4:0] rd, input logic [19:0] imm);
		logic [31:0] v;
		v = {imm, 12'b0} + (is_auipc ? cur_pc : 32'd0);
		push_inst({imm, rd, is_auipc ? 7'b0010111 : 7'b0110111}, make_res(rd, v, 1'b0, '0), 1'b0);
	endtask

	// lui plus addi, upper part rounded for the sign of the low 12 bits
	task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		do_u(1'b0, rd, hi[31:12]);
		do_ri(3'd0, rd, rd, v[11:0]);
	endtask

	task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] imm);
		logic taken;
		taken = br_ref(f3, model_regs[rs1], model_regs[rs2]);
		push_inst(enc_b(imm, rs2, rs1, f3),
			make_res(5'd0, cur_pc + 32'd4, taken, cur_pc + {{19{imm[12]}}, imm}), 1'b1);
	endtask

	task automatic do_jal(input logic [4:0] rd, input logic [20:0] imm);
		push_inst(enc_j(imm, rd),
			make_res(rd, cur_pc + 32'd4, 1'b1, cur_pc + {{11{imm[20]}}, imm}), 1'b1);
	endtask

	task automatic do_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		logic [31:0] target;
		target = (model_regs[rs1] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
		push_inst(enc_i(imm, rs1, 3'd0, rd, 7'b1100111),
			make_res(rd, cur_pc + 32'd4, 1'b1, target), 1'b1);
	endtask

	// strobe every queued instruction back to back and match results as they come
	task automatic run_queued();
		int cyc;
		int idle;
		cyc = 0;
		idle = 0;
		while (q_inst.size() > 0 || q_due.size() > 0) begin
			@(negedge clock);
			cyc++;
			check_flag("illegal", illegal, 1'b0);
			if (result_valid) begin
				if (q_due.size() == 0)
					abort_run("result_valid pulsed with no instruction in flight");
				check_count("result latency", cyc, q_due.pop_front());
				check_result(make_res(result_rd, result_value, branch_taken, branch_target),
					q_exp.pop_front(), q_is_br.pop_front());
				idle = 0;
			end else if (q_due.size() > 0) begin
				idle++;
				if (idle > 8)
					abort_run("timeout: result_valid never arrived");
			end
			if (q_inst.size() > 0) begin
				inst_valid = 1'b1;
				inst = q_inst.pop_front();
				pc = q_pc.pop_front();
				q_due.push_back(cyc + 2);
			end else begin
				inst_valid = 1'b0;
			end
		end
		@(negedge clock); // count updates one edge after the last result
		check_count("retire_count", retire_count, n_retired);
	endtask

	task automatic strobe_one(input logic [31:0] word);
		@(negedge clock);
		inst_valid = 1'b1;
		inst = word;
		pc = cur_pc;
		@(negedge clock);
		inst_valid = 1'b0;
	endtask

	task automatic expect_illegal(input logic [31:0] word);
		int n;
		strobe_one(word);
		n = 0;
		while (!illegal) begin
			@(negedge clock);
			n++;
			if (n > 8)
				abort_run("timeout: illegal never pulsed");
		end
		repeat (3) begin
			@(negedge clock);
			check_flag("result_valid", result_valid, 1'b0);
			check_flag("illegal", illegal, 1'b0); // one cycle pulse only
		end
		check_count("retire_count", retire_count, n_retired);
	endtask

	task automatic test_alu();
		logic [31:0] r;
		load_reg(5'd1, rand_word());
		load_reg(5'd2, rand_word());
		r = rand_word();
		do_u(1'b1, 5'd3, r[31:12]); // auipc
		for (int i = 0; i < 8; i++) begin
			do_rr(7'b0000000, 3'(i), 5'd3, 5'd1, 5'd2);
			r = rand_word();
			if (i == 1) begin
				do_ri(3'd1, 5'd4, 5'd1, {7'b0, r[4:0]});
			end else if (i == 5) begin
				do_ri(3'd5, 5'd4, 5'd1, {7'b0, r[4:0]});
				do_ri(3'd5, 5'd4, 5'd1, {7'b0100000, r[4:0]}); // srai
			end else begin
				do_ri(3'(i), 5'd4, 5'd1, r[11:0]);
			end
		end
		do_rr(7'b0100000, 3'd0, 5'd3, 5'd1, 5'd2);
		do_rr(7'b0100000, 3'd5, 5'd3, 5'd1, 5'd2);
		run_queued();
	endtask

	task automatic test_bypass();
		logic [4:0] prev;
		logic [4:0] rd;
		int pick;
		do_ri(3'd0, 5'd5, 5'd0, 12'h123);
		do_ri(3'd0, 5'd6, 5'd0, 12'h9a5);
		prev = 5'd6;
		for (int i = 0; i < 12; i++) begin
			rd = (prev == 5'd5) ? 5'd6 : 5'd5;
			pick = rand_word() % 3;
			case (pick)
				0: do_rr(7'b0000000, 3'd0, rd, prev, 5'd2);
				1: do_rr(7'b0100000, 3'd0, rd, prev, rd); // rd holds the value from two back
				default: do_rr(7'b0000000, 3'd4, rd, prev, 5'd1);
			endcase
			prev = rd;
		end
		run_queued();
	endtask

	task automatic test_mult();
		logic [31:0] edges [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h1};
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < 10; i++) begin
			if (i < 4) begin
				a = edges[i];
				b = edges[3 - i];
			end else if (i < 6) begin
				a = edges[i - 4];
				b = a;
			end else begin
				a = rand_word();
				b = rand_word();
			end
			load_reg(5'd7, a);
			load_reg(5'd8, b);
			for (int k = 0; k < 4; k++)
				do_rr(7'b0000001, 3'(k), 5'd9, 5'd7, 5'd8);
		end
		run_queued();
	endtask

	task automatic test_branch();
		logic [31:0] lhs [3] = '{32'd5, 32'hffff_fff0, 32'd3};
		logic [31:0] rhs [3] = '{32'd5, 32'd3, 32'hffff_fff0};
		logic [31:0] r;
		for (int i = 0; i < 3; i++) begin
			load_reg(5'd10, lhs[i]);
			load_reg(5'd11, rhs[i]);
			for (int k = 0; k < 8; k++) begin
				r = rand_word();
				if (k != 2 && k != 3)
					do_branch(3'(k), 5'd10, 5'd11, {r[12:1], 1'b0});
			end
		end
		r = rand_word();
		do_jal(5'd12, {r[20:1], 1'b0});
		do_jalr(5'd13, 5'd12, r[11:0]); // link value comes over the bypass
		do_jalr(5'd14, 5'd10, r[31:20]);
		run_queued();
	endtask

	task automatic test_illegal_halt();
		int n;
		expect_illegal({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, 7'b0100011}); // sw
		expect_illegal(32'hffff_ffff);
		if (REG_COUNT < 32)
			expect_illegal(enc_r(7'b0, 5'd1, 5'd2, 3'd0, 5'(REG_COUNT)));
		strobe_one(32'h1050_0073); // wfi
		n = 0;
		while (!halt) begin
			@(negedge clock);
			n++;
			if (n > 8)
				abort_run("timeout: halt never rose");
		end
		check_flag("illegal", illegal, 1'b0);
		strobe_one(enc_i(12'h001, 5'd0, 3'd0, 5'd1, 7'b0010011));
		repeat (4) begin
			@(negedge clock);
			check_flag("result_valid", result_valid, 1'b0);
			check_flag("halt", halt, 1'b1);
			check_flag("illegal", illegal, 1'b0);
		end
		check_count("retire_count", retire_count, n_retired);
	endtask

	initial begin
		seed = 32'h42361880;
		clock = 1'b0;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		cur_pc = 32'h0000_1000;
		n_retired = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
		check_flag("result_valid", result_valid, 1'b0);
		check_flag("illegal", illegal, 1'b0);
		check_flag("halt", halt, 1'b0);
		check_count("retire_count", retire_count, 32'd0);
		test_alu();
		test_bypass();
		test_mult();
		test_branch();
		test_illegal_halt();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
